// File: logic/bus_pkg.sv
package bus_pkg;

	localparam int BUS_WIDTH = 32;

	// 1024 words, 4 KiB span
	localparam int RAM_ADDR_BITS = 10;
	localparam int RAM_WORDS = 1 << RAM_ADDR_BITS;

	localparam int RAM_WAIT_STATES = 2;
	localparam int RAM_WAIT_BITS = $clog2(RAM_WAIT_STATES + 1);

	localparam int DMA_COUNT_BITS = 10;

	// DMA copier states
	localparam logic [1:0] DMA_IDLE  = 2'd0;
	localparam logic [1:0] DMA_READ  = 2'd1;
	localparam logic [1:0] DMA_WRITE = 2'd2;
	localparam logic [1:0] DMA_DONE  = 2'd3;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,
		ARB_PORT_B,
		ARB_PORT_C
	} arb_state_t;

endpackage

// File: logic/bus_access.sv
module bus_access
	import bus_pkg::*;
(
	input  logic                 i_clock,
	input  logic                 i_reset,

	// Shared bus
	output logic                 o_bus_rw,
	output logic                 o_bus_request,
	input  logic                 i_bus_ready,
	output logic [BUS_WIDTH-1:0] o_bus_address,
	input  logic [BUS_WIDTH-1:0] i_bus_rdata,
	output logic [BUS_WIDTH-1:0] o_bus_wdata,

	// Port A, fetch, read only
	input  logic                 i_pa_request,
	output logic                 o_pa_ready,
	input  logic [BUS_WIDTH-1:0] i_pa_address,
	output logic [BUS_WIDTH-1:0] o_pa_rdata,
	output logic                 o_pa_busy,

	// Port B, load/store
	input  logic                 i_pb_rw,
	input  logic                 i_pb_request,
	output logic                 o_pb_ready,
	input  logic [BUS_WIDTH-1:0] i_pb_address,
	output logic [BUS_WIDTH-1:0] o_pb_rdata,
	input  logic [BUS_WIDTH-1:0] i_pb_wdata,
	output logic                 o_pb_busy,

	// Port C, DMA
	input  logic                 i_pc_rw,
	input  logic                 i_pc_request,
	output logic                 o_pc_ready,
	input  logic [BUS_WIDTH-1:0] i_pc_address,
	output logic [BUS_WIDTH-1:0] o_pc_rdata,
	input  logic [BUS_WIDTH-1:0] i_pc_wdata
);

	arb_state_t state;
	arb_state_t grant;

	// Fixed priority B > A > C
	always_comb begin
		if (i_pb_request) begin
			grant = ARB_PORT_B;
		end else if (i_pa_request) begin
			grant = ARB_PORT_A;
		end else if (i_pc_request) begin
			grant = ARB_PORT_C;
		end else begin
			grant = ARB_IDLE;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					state <= grant;
				end
				ARB_PORT_A, ARB_PORT_B, ARB_PORT_C: begin
					if (i_bus_ready) begin
						state <= ARB_IDLE;	// Always one idle cycle between grants
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Winner's command, held until ready
	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE) begin
			case (grant)
				ARB_PORT_B: begin
					o_bus_rw      <= i_pb_rw;
					o_bus_address <= i_pb_address;
					o_bus_wdata   <= i_pb_wdata;
				end
				ARB_PORT_A: begin
					o_bus_rw      <= 1'b0;
					o_bus_address <= i_pa_address;
				end
				ARB_PORT_C: begin
					o_bus_rw      <= i_pc_rw;
					o_bus_address <= i_pc_address;
					o_bus_wdata   <= i_pc_wdata;
				end
				default: begin
					o_bus_rw <= 1'b0;
				end
			endcase
		end
	end

	assign o_bus_request = (state != ARB_IDLE);

	assign o_pa_ready = i_pa_request && (state == ARB_PORT_A) && i_bus_ready;
	assign o_pb_ready = i_pb_request && (state == ARB_PORT_B) && i_bus_ready;
	assign o_pc_ready = i_pc_request && (state == ARB_PORT_C) && i_bus_ready;

	// Read data shared by all ports
	assign o_pa_rdata = i_bus_rdata;
	assign o_pb_rdata = i_bus_rdata;
	assign o_pc_rdata = i_bus_rdata;

	assign o_pa_busy = (state == ARB_PORT_A);
	assign o_pb_busy = (state == ARB_PORT_B);

endmodule

// File: logic/bus_ram.sv
module bus_ram
	import bus_pkg::*;
(
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_bus_request,
	input  logic                 i_bus_rw,
	input  logic [BUS_WIDTH-1:0] i_bus_address,
	input  logic [BUS_WIDTH-1:0] i_bus_wdata,
	output logic                 o_bus_ready,
	output logic [BUS_WIDTH-1:0] o_bus_rdata
);

	logic [BUS_WIDTH-1:0]     mem [RAM_WORDS];
	logic [RAM_ADDR_BITS-1:0] word_index;
	logic [RAM_WAIT_BITS-1:0] wait_count;
	logic                     served;	// Set until request drops
	logic                     fire;

	// Upper address bits wrap
	assign word_index = i_bus_address[RAM_ADDR_BITS+1:2];

	assign fire = i_bus_request && !served
		&& (wait_count == RAM_WAIT_BITS'(RAM_WAIT_STATES - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count  <= '0;
			served      <= 1'b0;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= fire;
			if (!i_bus_request) begin
				// Rearm
				served     <= 1'b0;
				wait_count <= '0;
			end else if (fire) begin
				served     <= 1'b1;
				wait_count <= '0;
			end else if (!served) begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	// Access lands together with ready
	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_bus_rw) begin
				mem[word_index] <= i_bus_wdata;
			end
			o_bus_rdata <= mem[word_index];
		end
	end

endmodule

// File: logic/dma_copier.sv
module dma_copier
	import bus_pkg::*;
(
	input  logic                      i_clock,
	input  logic                      i_reset,

	// Command
	input  logic                      i_dma_start,
	input  logic [BUS_WIDTH-1:0]      i_dma_src,
	input  logic [BUS_WIDTH-1:0]      i_dma_dst,
	input  logic [DMA_COUNT_BITS-1:0] i_dma_count,
	output logic                      o_dma_busy,
	output logic                      o_dma_done,

	// Port C master side
	output logic                      o_pc_rw,
	output logic                      o_pc_request,
	input  logic                      i_pc_ready,
	output logic [BUS_WIDTH-1:0]      o_pc_address,
	input  logic [BUS_WIDTH-1:0]      i_pc_rdata,
	output logic [BUS_WIDTH-1:0]      o_pc_wdata
);

	logic [1:0]                state;
	logic [BUS_WIDTH-1:0]      src_address;
	logic [BUS_WIDTH-1:0]      dst_address;
	logic [DMA_COUNT_BITS-1:0] remaining;
	logic [BUS_WIDTH-1:0]      copy_word;
	logic                      last_word;

	assign last_word = (remaining == DMA_COUNT_BITS'(1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= DMA_IDLE;
		end else begin
			case (state)
				DMA_IDLE: begin
					if (i_dma_start) begin
						// Zero count goes straight to done
						state <= (i_dma_count == '0) ? DMA_DONE : DMA_READ;
					end
				end
				DMA_READ: begin
					if (i_pc_ready) begin
						state <= DMA_WRITE;
					end
				end
				DMA_WRITE: begin
					if (i_pc_ready) begin
						state <= last_word ? DMA_DONE : DMA_READ;
					end
				end
				default: begin
					state <= DMA_IDLE;
				end
			endcase
		end
	end

	// Addresses, count and the word in flight
	always_ff @(posedge i_clock) begin
		if (state == DMA_IDLE && i_dma_start) begin
			src_address <= i_dma_src;
			dst_address <= i_dma_dst;
			remaining   <= i_dma_count;
		end

		if (state == DMA_READ && i_pc_ready) begin
			copy_word <= i_pc_rdata;
		end

		if (state == DMA_WRITE && i_pc_ready) begin
			src_address <= src_address + BUS_WIDTH'(4);
			dst_address <= dst_address + BUS_WIDTH'(4);
			remaining   <= remaining - 1'b1;
		end
	end

	assign o_dma_busy = (state != DMA_IDLE);
	assign o_dma_done = (state == DMA_DONE);

	// Command held steady from registers until ready
	assign o_pc_request = (state == DMA_READ) || (state == DMA_WRITE);
	assign o_pc_rw      = (state == DMA_WRITE);
	assign o_pc_address = o_pc_rw ? dst_address : src_address;
	assign o_pc_wdata   = copy_word;

endmodule

// File: logic/bus_subsystem.sv
module bus_subsystem
	import bus_pkg::*;
(
	input  logic                      i_clock,
	input  logic                      i_reset,

	// Port A, fetch
	input  logic                      i_pa_request,
	output logic                      o_pa_ready,
	input  logic [BUS_WIDTH-1:0]      i_pa_address,
	output logic [BUS_WIDTH-1:0]      o_pa_rdata,
	output logic                      o_pa_busy,

	// Port B, load/store
	input  logic                      i_pb_rw,
	input  logic                      i_pb_request,
	output logic                      o_pb_ready,
	input  logic [BUS_WIDTH-1:0]      i_pb_address,
	output logic [BUS_WIDTH-1:0]      o_pb_rdata,
	input  logic [BUS_WIDTH-1:0]      i_pb_wdata,
	output logic                      o_pb_busy,

	// DMA control
	input  logic                      i_dma_start,
	input  logic [BUS_WIDTH-1:0]      i_dma_src,
	input  logic [BUS_WIDTH-1:0]      i_dma_dst,
	input  logic [DMA_COUNT_BITS-1:0] i_dma_count,
	output logic                      o_dma_busy,
	output logic                      o_dma_done
);

	logic                 bus_rw;
	logic                 bus_request;
	logic                 bus_ready;
	logic [BUS_WIDTH-1:0] bus_address;
	logic [BUS_WIDTH-1:0] bus_rdata;
	logic [BUS_WIDTH-1:0] bus_wdata;

	logic                 pc_rw;
	logic                 pc_request;
	logic                 pc_ready;
	logic [BUS_WIDTH-1:0] pc_address;
	logic [BUS_WIDTH-1:0] pc_rdata;
	logic [BUS_WIDTH-1:0] pc_wdata;

	bus_access i_bus_access (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.o_bus_rw      (bus_rw),
		.o_bus_request (bus_request),
		.i_bus_ready   (bus_ready),
		.o_bus_address (bus_address),
		.i_bus_rdata   (bus_rdata),
		.o_bus_wdata   (bus_wdata),
		.i_pa_request  (i_pa_request),
		.o_pa_ready    (o_pa_ready),
		.i_pa_address  (i_pa_address),
		.o_pa_rdata    (o_pa_rdata),
		.o_pa_busy     (o_pa_busy),
		.i_pb_rw       (i_pb_rw),
		.i_pb_request  (i_pb_request),
		.o_pb_ready    (o_pb_ready),
		.i_pb_address  (i_pb_address),
		.o_pb_rdata    (o_pb_rdata),
		.i_pb_wdata    (i_pb_wdata),
		.o_pb_busy     (o_pb_busy),
		.i_pc_rw       (pc_rw),
		.i_pc_request  (pc_request),
		.o_pc_ready    (pc_ready),
		.i_pc_address  (pc_address),
		.o_pc_rdata    (pc_rdata),
		.i_pc_wdata    (pc_wdata)
	);

	bus_ram i_bus_ram (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

	dma_copier i_dma_copier (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_dma_start  (i_dma_start),
		.i_dma_src    (i_dma_src),
		.i_dma_dst    (i_dma_dst),
		.i_dma_count  (i_dma_count),
		.o_dma_busy   (o_dma_busy),
		.o_dma_done   (o_dma_done),
		.o_pc_rw      (pc_rw),
		.o_pc_request (pc_request),
		.i_pc_ready   (pc_ready),
		.o_pc_address (pc_address),
		.i_pc_rdata   (pc_rdata),
		.o_pc_wdata   (pc_wdata)
	);

endmodule

// File: dv/bus_access_sva.sv
module bus_access_sva
	import bus_pkg::*;
(
	input logic                 i_clock,
	input logic                 i_reset,
	input arb_state_t           state,
	input logic                 o_bus_request,
	input logic                 o_bus_rw,
	input logic                 i_bus_ready,
	input logic [BUS_WIDTH-1:0] o_bus_address,
	input logic [BUS_WIDTH-1:0] o_bus_wdata,
	input logic                 o_pa_ready,
	input logic                 o_pb_ready,
	input logic                 o_pc_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	// Command held until the RAM answers
	command_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_rw)
			&& $stable(o_bus_address) && $stable(o_bus_wdata))
		else $error("bus command changed before ready");

	// Every RAM answer reaches exactly one port
	one_port_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> $onehot({o_pa_ready, o_pb_ready, o_pc_ready}))
		else $error("bus ready did not reach exactly one port");

	ready_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_bus_request) |-> ##RAM_WAIT_STATES i_bus_ready)
		else $error("bus ready not seen after the wait states");

	// Idle cycle after every grant
	idle_after_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && i_bus_ready |=> state == ARB_IDLE)
		else $error("arbiter did not return to idle after ready");

endmodule

bind bus_access bus_access_sva i_bus_access_sva (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.state         (state),
	.o_bus_request (o_bus_request),
	.o_bus_rw      (o_bus_rw),
	.i_bus_ready   (i_bus_ready),
	.o_bus_address (o_bus_address),
	.o_bus_wdata   (o_bus_wdata),
	.o_pa_ready    (o_pa_ready),
	.o_pb_ready    (o_pb_ready),
	.o_pc_ready    (o_pc_ready)
);

// File: dv/bus_subsystem_tb.sv
module bus_subsystem_tb
	import bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PORT_TIMEOUT = 64;
	localparam int DMA_TIMEOUT  = 4000;

	logic                      i_clock;
	logic                      i_reset;
	logic                      i_pa_request;
	logic                      o_pa_ready;
	logic [BUS_WIDTH-1:0]      i_pa_address;
	logic [BUS_WIDTH-1:0]      o_pa_rdata;
	logic                      o_pa_busy;
	logic                      i_pb_rw;
	logic                      i_pb_request;
	logic                      o_pb_ready;
	logic [BUS_WIDTH-1:0]      i_pb_address;
	logic [BUS_WIDTH-1:0]      o_pb_rdata;
	logic [BUS_WIDTH-1:0]      i_pb_wdata;
	logic                      o_pb_busy;
	logic                      i_dma_start;
	logic [BUS_WIDTH-1:0]      i_dma_src;
	logic [BUS_WIDTH-1:0]      i_dma_dst;
	logic [DMA_COUNT_BITS-1:0] i_dma_count;
	logic                      o_dma_busy;
	logic                      o_dma_done;

	logic [BUS_WIDTH-1:0] model [RAM_WORDS];	// Expected RAM contents
	time                  pa_ready_time;
	time                  pb_ready_time;

	bus_subsystem i_dut (.*);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [BUS_WIDTH-1:0] actual,
		input logic [BUS_WIDTH-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
		end
	endtask

	// Byte address bits [11:2] pick the word, higher bits wrap
	function automatic int word_of(input logic [BUS_WIDTH-1:0] address);
		return int'(address[RAM_ADDR_BITS+1:2]);
	endfunction

	function automatic logic [BUS_WIDTH-1:0] fill_pattern(input logic [RAM_ADDR_BITS-1:0] index);
		return {6'h2b, index, 6'h15, ~index};
	endfunction

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge i_clock);
		#1;
	endtask

	task automatic port_a_read(input logic [BUS_WIDTH-1:0] address);
		int                   cycles;
		logic [BUS_WIDTH-1:0] data;
		i_pa_address = address;
		i_pa_request = 1'b1;
		cycles       = 0;
		do begin
			@(negedge i_clock);
			cycles++;
			if (cycles > PORT_TIMEOUT) begin
				abort_run("port A read timed out waiting for ready");
			end
		end while (!o_pa_ready);
		data          = o_pa_rdata;
		pa_ready_time = $time;
		@(posedge i_clock);
		#1;
		i_pa_request = 1'b0;
		check_value("o_pa_rdata", data, model[word_of(address)]);
	endtask

	task automatic port_b_access(input logic rw, input logic [BUS_WIDTH-1:0] address,
		input logic [BUS_WIDTH-1:0] wdata, output logic [BUS_WIDTH-1:0] rdata);
		int cycles;
		i_pb_rw      = rw;
		i_pb_address = address;
		i_pb_wdata   = wdata;
		i_pb_request = 1'b1;
		cycles       = 0;
		do begin
			@(negedge i_clock);
			cycles++;
			if (cycles > PORT_TIMEOUT) begin
				abort_run("port B access timed out waiting for ready");
			end
		end while (!o_pb_ready);
		rdata         = o_pb_rdata;
		pb_ready_time = $time;
		@(posedge i_clock);
		#1;
		i_pb_request = 1'b0;
	endtask

	task automatic port_b_write(input logic [BUS_WIDTH-1:0] address,
		input logic [BUS_WIDTH-1:0] data);
		logic [BUS_WIDTH-1:0] old_word;
		port_b_access(1'b1, address, data, old_word);
		model[word_of(address)] = data;
	endtask

	task automatic port_b_read(input logic [BUS_WIDTH-1:0] address);
		logic [BUS_WIDTH-1:0] data;
		port_b_access(1'b0, address, '0, data);
		check_value("o_pb_rdata", data, model[word_of(address)]);
	endtask

	task automatic dma_run(input logic [BUS_WIDTH-1:0] src, input logic [BUS_WIDTH-1:0] dst,
		input logic [DMA_COUNT_BITS-1:0] count);
		int cycles;
		int i;
		i_dma_src   = src;
		i_dma_dst   = dst;
		i_dma_count = count;
		i_dma_start = 1'b1;
		@(posedge i_clock);
		#1;
		i_dma_start = 1'b0;
		cycles      = 0;
		do begin
			@(negedge i_clock);
			cycles++;
			if (cycles > DMA_TIMEOUT) begin
				abort_run("DMA copy timed out waiting for done");
			end
			if (!o_dma_done) begin
				check_value("o_dma_busy", BUS_WIDTH'(o_dma_busy), 1);
			end
		end while (!o_dma_done);
		if (count == '0) begin
			check_value("cycles from start to o_dma_done", BUS_WIDTH'(cycles), 1);
		end
		// Word by word, in copy order
		for (i = 0; i < int'(count); i++) begin
			model[word_of(dst + BUS_WIDTH'(4 * i))] = model[word_of(src + BUS_WIDTH'(4 * i))];
		end
		@(posedge i_clock);
		#1;
		check_value("{dma_busy,dma_done}", BUS_WIDTH'({o_dma_busy, o_dma_done}), '0);	// Done lasts one cycle
	endtask

	task automatic after_reset_test();
		repeat (8) begin
			@(negedge i_clock);
			check_value("{pa_ready,pb_ready,pa_busy,pb_busy,dma_busy,dma_done}",
				BUS_WIDTH'({o_pa_ready, o_pb_ready, o_pa_busy, o_pb_busy, o_dma_busy, o_dma_done}),
				'0);
		end
		@(posedge i_clock);
		#1;
		port_b_write(32'h0000_0ab4, 32'h1234_5678);
		port_b_read(32'h0000_0ab4);
	endtask

	task automatic fill_memory();
		int i;
		for (i = 0; i < RAM_WORDS; i++) begin
			port_b_write(BUS_WIDTH'(i) << 2, fill_pattern(RAM_ADDR_BITS'(i)));
		end
	endtask

	task automatic fetch_test();
		logic [BUS_WIDTH-1:0] address;
		repeat (16) begin
			address = $urandom_range(RAM_WORDS - 1, 0) << 2;
			port_b_write(address, $urandom);
			port_a_read(address + ($urandom_range(15, 1) << 12));	// Aliased copy
		end
	endtask

	task automatic priority_test();
		repeat (4) begin
			fork
				port_a_read($urandom_range(511, 0) << 2);
				port_b_read(32'h0000_0800 + ($urandom_range(511, 0) << 2));
			join
			check_value("pb_ready_time < pa_ready_time",
				BUS_WIDTH'(pb_ready_time < pa_ready_time), 1);
		end
	endtask

	task automatic dma_copy_test();
		int i;
		for (i = 0; i < 16; i++) begin
			port_b_write(32'h0000_0400 + BUS_WIDTH'(4 * i), $urandom);
		end
		dma_run(32'h0000_0400, 32'h0000_0600, DMA_COUNT_BITS'(16));
		for (i = -4; i < 20; i++) begin
			port_a_read(32'h0000_0600 + BUS_WIDTH'(4 * i));	// Margins stay untouched
		end
		for (i = 0; i < 16; i++) begin
			port_a_read(32'h0000_0400 + BUS_WIDTH'(4 * i));
		end
		// Zero count, no bus traffic expected
		dma_run(32'h0000_0480, 32'h0000_0680, '0);
		for (i = 0; i < 4; i++) begin
			port_a_read(32'h0000_0680 + BUS_WIDTH'(4 * i));
		end
	endtask

	task automatic fetch_traffic(input int count);
		repeat (count) begin
			port_a_read($urandom_range(63, 0) << 2);
			idle_cycles(int'($urandom_range(3, 1)));
		end
	endtask

	task automatic load_store_traffic(input int count);
		logic [BUS_WIDTH-1:0] address;
		repeat (count) begin
			address = 32'h0000_0200 + ($urandom_range(63, 0) << 2);
			if ($urandom_range(1, 0) == 1) begin
				port_b_write(address, $urandom);
			end else begin
				port_b_read(address);
			end
			idle_cycles(int'($urandom_range(3, 1)));
		end
	endtask

	task automatic dma_traffic_test();
		int i;
		for (i = 0; i < 16; i++) begin
			port_b_write(32'h0000_0a00 + BUS_WIDTH'(4 * i), $urandom);
		end
		fork
			dma_run(32'h0000_0a00, 32'h0000_0c00, DMA_COUNT_BITS'(16));
			fetch_traffic(12);
			load_store_traffic(12);
		join
		for (i = 0; i < 16; i++) begin
			port_a_read(32'h0000_0c00 + BUS_WIDTH'(4 * i));
		end
	endtask

	// A and B never own the bus together
	always @(negedge i_clock) begin
		if (!i_reset && o_pa_busy && o_pb_busy) begin
			abort_run("ports A and B were granted the bus at the same time");
		end
	end

	initial begin
		void'($urandom(32'hb8a4));
		i_reset      = 1'b1;
		i_pa_request = 1'b0;
		i_pa_address = '0;
		i_pb_rw      = 1'b0;
		i_pb_request = 1'b0;
		i_pb_address = '0;
		i_pb_wdata   = '0;
		i_dma_start  = 1'b0;
		i_dma_src    = '0;
		i_dma_dst    = '0;
		i_dma_count  = '0;
		repeat (16) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		after_reset_test();
		fill_memory();
		fetch_test();
		priority_test();
		dma_copy_test();
		dma_traffic_test();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: sources.f
logic/bus_pkg.sv
logic/bus_access.sv
logic/bus_ram.sv
logic/dma_copier.sv
logic/bus_subsystem.sv
dv/bus_access_sva.sv
dv/bus_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build the bus subsystem testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bus_subsystem_tb -f sources.f \
	&& ./obj_dir/Vbus_subsystem_tb > sim.log 2>&1
status=$?
[ -f sim.log ] && cat sim.log
grep -qsF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
[ "$status" -eq 0 ] || { echo "Build or simulation ended with an error"; exit 1; }
grep -qsF "*** TEST PASSED ***" sim.log || { echo "No pass report in the log"; exit 1; }
echo "Simulation passed"
